// ==== asi_aes_execute.sv ====
// AES SubBytes / MixColumns word datapath
// - Single cycle form per parameter
// - Byte-serial form with shared S-box or mix row and holding register
// - Ready generation from the byte counter
`timescale 1ns/10ps

module asi_aes_execute #(
    parameter bit AES_SUB_FAST = 1'b1,  // SubBytes in one cycle
    parameter bit AES_MIX_FAST = 1'b1   // MixColumns in one cycle
) (
    input  logic                         g_clk,
    input  logic                         reset,      // Sync, active high
    input  logic                         cls_aes,    // Valid AES op
    input  logic                         aes_mix,    // MixColumns if set
    input  logic                         aes_dec,    // Decrypt if set
    input  logic [asi_isa_pkg::XLEN-1:0] asi_rs1,
    input  logic [asi_isa_pkg::XLEN-1:0] asi_rs2,
    output logic                         aes_ready,
    output logic [asi_isa_pkg::XLEN-1:0] result_aes
);

    logic [31:0] col;         // Gathered MixColumns column
    logic [31:0] fast_sub;
    logic [31:0] fast_mix;
    logic        iter_op;     // Current op runs byte-serial
    logic [1:0]  byte_cnt;
    logic        last_byte;
    logic [7:0]  sub_byte;
    logic [7:0]  mix_byte;
    logic [7:0]  iter_byte;
    logic [31:0] hold;        // Finished bytes 0..2

    // Two-operand column, byte 0 lowest
    assign col = {asi_rs2[31:16], asi_rs1[15:0]};

    // ------------------------------------------------------------
    // Single cycle forms
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            fast_sub[8*i +: 8] = aes_dec ? asi_aes_pkg::aes_inv_sbox(asi_rs1[8*i +: 8])
                                         : asi_aes_pkg::aes_sbox(asi_rs1[8*i +: 8]);
        end
    end

    assign fast_mix = aes_dec ? asi_aes_pkg::aes_inv_mix_col(col)
                              : asi_aes_pkg::aes_mix_col(col);

    // ------------------------------------------------------------
    // Byte-serial form
    assign iter_op   = aes_mix ? !AES_MIX_FAST : !AES_SUB_FAST;
    assign last_byte = (byte_cnt == 2'd3);

    // One shared S-box and one mix row
    assign sub_byte  = aes_dec ? asi_aes_pkg::aes_inv_sbox(asi_rs1[8*byte_cnt +: 8])
                               : asi_aes_pkg::aes_sbox(asi_rs1[8*byte_cnt +: 8]);
    assign mix_byte  = asi_aes_pkg::aes_mix_row(col, byte_cnt, aes_dec);
    assign iter_byte = aes_mix ? mix_byte : sub_byte;

    always_ff @(posedge g_clk) begin
        if (reset) begin
            byte_cnt <= 2'd0;
        end else if (cls_aes && iter_op && !last_byte) begin
            byte_cnt <= byte_cnt + 2'd1;  // Next byte
        end else begin
            byte_cnt <= 2'd0;             // Done, idle or valid dropped
        end
    end

    always_ff @(posedge g_clk) begin
        if (cls_aes && iter_op) hold[8*byte_cnt +: 8] <= iter_byte;
    end

    // ------------------------------------------------------------
    // Result and ready
    assign aes_ready  = cls_aes && (!iter_op || last_byte);  // 4th cycle if serial

    // Final byte bypasses the holding register
    assign result_aes = !iter_op ? (aes_mix ? fast_mix : fast_sub)
                                 : {iter_byte, hold[23:0]};

endmodule

// ==== asi_aes_pkg.sv ====
// AES arithmetic over GF(2^8)
// - xtime, full multiply, inverse as x^254
// - Forward and inverse S-box
// - MixColumns row and column, forward and inverse
package asi_aes_pkg;

    // Multiply by x, reduce by 0x11b
    function automatic logic [7:0] gf_mul2(input logic [7:0] a);
        return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
    endfunction

    // Shift-and-add multiply
    function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] r;
        logic [7:0] p;
        r = 8'h00;
        p = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) r = r ^ p;
            p = gf_mul2(p);
        end
        return r;
    endfunction

    // x^254 = x^2 * x^4 * ... * x^128, so inv(0) stays 0
    function automatic logic [7:0] gf_inv(input logic [7:0] a);
        logic [7:0] r;
        logic [7:0] p;
        r = 8'h01;
        p = a;
        for (int i = 0; i < 7; i++) begin
            p = gf_mul(p, p);   // Next power of two
            r = gf_mul(r, p);
        end
        return r;
    endfunction

    function automatic logic [7:0] aes_sbox(input logic [7:0] a);
        logic [7:0] b;
        b = gf_inv(a);
        // Affine transform
        return b ^ {b[6:0], b[7]} ^ {b[5:0], b[7:6]} ^ {b[4:0], b[7:5]} ^
               {b[3:0], b[7:4]} ^ 8'h63;
    endfunction

    function automatic logic [7:0] aes_inv_sbox(input logic [7:0] a);
        logic [7:0] b;
        // Inverse affine first
        b = {a[6:0], a[7]} ^ {a[4:0], a[7:5]} ^ {a[1:0], a[7:2]} ^ 8'h05;
        return gf_inv(b);
    endfunction

    // One output byte of (Inv)MixColumns, byte 0 is the low byte
    function automatic logic [7:0] aes_mix_row(input logic [31:0] col,
                                               input logic [1:0]  row,
                                               input logic        dec);
        logic [3:0][7:0] coef;
        logic [7:0]      r;
        logic [1:0]      idx;
        coef = dec ? {8'h09, 8'h0d, 8'h0b, 8'h0e}  // 14,11,13,9
                   : {8'h01, 8'h01, 8'h03, 8'h02}; // 2,3,1,1
        r = 8'h00;
        for (int j = 0; j < 4; j++) begin
            idx = row + 2'(j);  // Wraps around the column
            r   = r ^ gf_mul(coef[j], col[8*idx +: 8]);
        end
        return r;
    endfunction

    function automatic logic [31:0] aes_mix_col(input logic [31:0] col);
        logic [31:0] r;
        for (int i = 0; i < 4; i++) r[8*i +: 8] = aes_mix_row(col, 2'(i), 1'b0);
        return r;
    endfunction

    function automatic logic [31:0] aes_inv_mix_col(input logic [31:0] col);
        logic [31:0] r;
        for (int i = 0; i < 4; i++) r[8*i +: 8] = aes_mix_row(col, 2'(i), 1'b1);
        return r;
    endfunction

endpackage

// ==== asi_decode.sv ====
// Micro-op decode for the algorithm specific unit
// - Class strobes qualified by valid
// - One-hot SHA3 function strobes
// - Gated SHA-256 operand and AES controls
`timescale 1ns/10ps

module asi_decode (
    input  logic                           asi_valid,  // Op present
    input  asi_isa_pkg::asi_uop_t          asi_uop,    // Which op
    input  logic [asi_isa_pkg::XLEN-1:0]   asi_rs1,    // Source register 1
    output logic                           cls_aes,
    output logic                           cls_sha2,
    output logic                           cls_sha3,
    output logic                           cls_none,   // Unknown class
    output logic                           f_xy,
    output logic                           f_x1,
    output logic                           f_x2,
    output logic                           f_x4,
    output logic                           f_yx,
    output logic [asi_isa_pkg::XLEN-1:0]   sha2_rs1,   // Zero unless SHA2
    output logic [1:0]                     sha2_ss,    // Sigma select
    output logic                           aes_mix,    // MixColumns if set
    output logic                           aes_dec     // Decrypt if set
);

    logic [1:0] cls;
    logic [2:0] fn;

    assign cls = asi_uop.func.cls;
    assign fn  = asi_uop.func.fn;

    // ------------------------------------------------------------
    // Class decode
    assign cls_aes  = asi_valid && (cls == asi_isa_pkg::CLS_AES);
    assign cls_sha2 = asi_valid && (cls == asi_isa_pkg::CLS_SHA2);
    assign cls_sha3 = asi_valid && (cls == asi_isa_pkg::CLS_SHA3);
    assign cls_none = asi_valid && (cls == asi_isa_pkg::CLS_NONE);

    // SHA3 functions, codes 5..7 leave all low
    assign f_xy = cls_sha3 && (fn == asi_isa_pkg::F_SHA3_XY);
    assign f_x1 = cls_sha3 && (fn == asi_isa_pkg::F_SHA3_X1);
    assign f_x2 = cls_sha3 && (fn == asi_isa_pkg::F_SHA3_X2);
    assign f_x4 = cls_sha3 && (fn == asi_isa_pkg::F_SHA3_X4);
    assign f_yx = cls_sha3 && (fn == asi_isa_pkg::F_SHA3_YX);

    // Keeps the sigma logic quiet for other classes
    assign sha2_rs1 = {asi_isa_pkg::XLEN{cls_sha2}} & asi_rs1;
    assign sha2_ss  = fn[1:0];

    // AES view of the same word
    assign aes_mix = asi_uop.aes.mix;
    assign aes_dec = asi_uop.aes.dec;

endmodule

// ==== asi_isa_pkg.sv ====
// Instruction-level definitions for the algorithm specific unit
// - Data word and micro-op widths
// - Class codes and SHA3 / SHA-256 function codes
// - Micro-op union with function and AES views
package asi_isa_pkg;

    localparam int XLEN  = 32;  // Data word width
    localparam int UOP_W = 5;   // Micro-op width

    // ------------------------------------------------------------
    // Class codes, uop[4:3]
    localparam logic [1:0] CLS_NONE = 2'b00;  // Unknown, completes with zero
    localparam logic [1:0] CLS_AES  = 2'b01;
    localparam logic [1:0] CLS_SHA2 = 2'b10;
    localparam logic [1:0] CLS_SHA3 = 2'b11;

    // SHA3 lane index functions, uop[2:0]
    localparam logic [2:0] F_SHA3_XY = 3'd0;
    localparam logic [2:0] F_SHA3_X1 = 3'd1;
    localparam logic [2:0] F_SHA3_X2 = 3'd2;
    localparam logic [2:0] F_SHA3_X4 = 3'd3;
    localparam logic [2:0] F_SHA3_YX = 3'd4;  // 5..7 give zero

    // SHA-256 sigma selector, uop[1:0]
    localparam logic [1:0] F_SHA2_S0_SMALL = 2'd0;  // ror7  ^ ror18 ^ shr3
    localparam logic [1:0] F_SHA2_S1_SMALL = 2'd1;  // ror17 ^ ror19 ^ shr10
    localparam logic [1:0] F_SHA2_S0_BIG   = 2'd2;  // ror2  ^ ror13 ^ ror22
    localparam logic [1:0] F_SHA2_S1_BIG   = 2'd3;  // ror6  ^ ror11 ^ ror25

    // ------------------------------------------------------------
    // Micro-op views
    typedef struct packed {
        logic [1:0] cls;   // Class code
        logic [2:0] fn;    // SHA2 / SHA3 function
    } asi_func_view_t;

    typedef struct packed {
        logic [1:0] cls;   // Class code
        logic       rsvd;  // Unused by AES
        logic       mix;   // 1 MixColumns, 0 SubBytes
        logic       dec;   // 1 decrypt
    } asi_aes_view_t;

    // Same 5-bit word, decoded per class
    typedef union packed {
        asi_func_view_t func;
        asi_aes_view_t  aes;
    } asi_uop_t;

endpackage

// ==== asi_sha_execute.sv ====
// SHA execute block
// - SHA3 lane index functions xy, x1, x2, x4, yx with post shift
// - SHA-256 sigma0, sigma1, Sigma0, Sigma1
`timescale 1ns/10ps

module asi_sha_execute (
    input  logic [asi_isa_pkg::XLEN-1:0] asi_rs1,      // x source
    input  logic [asi_isa_pkg::XLEN-1:0] asi_rs2,      // y source
    input  logic [1:0]                   asi_shamt,    // Post shift
    input  logic                         f_xy,         // One-hot SHA3 function
    input  logic                         f_x1,
    input  logic                         f_x2,
    input  logic                         f_x4,
    input  logic                         f_yx,
    input  logic [asi_isa_pkg::XLEN-1:0] sha2_rs1,     // Gated operand
    input  logic [1:0]                   sha2_ss,      // Sigma select
    output logic [asi_isa_pkg::XLEN-1:0] result_sha2,
    output logic [asi_isa_pkg::XLEN-1:0] result_sha3
);

    localparam int XL = asi_isa_pkg::XLEN;

    function automatic logic [2:0] mod5(input logic [7:0] v);
        return 3'(v % 8'd5);
    endfunction

    // Lane index col + 5*row, at most 24
    function automatic logic [4:0] lane(input logic [2:0] c, input logic [2:0] r);
        return 5'(c) + 5'(r) * 5'd5;
    endfunction

    function automatic logic [XL-1:0] ror(input logic [XL-1:0] v, input int n);
        return (v >> n) | (v << (XL - n));
    endfunction

    // ------------------------------------------------------------
    // SHA3 indexing
    logic [2:0] x;
    logic [2:0] y;
    logic [4:0] sha3_lane;

    assign x = mod5(asi_rs1[7:0]);  // Low byte only
    assign y = mod5(asi_rs2[7:0]);

    assign sha3_lane =
        ({5{f_xy}} & lane(x, y))                       |
        ({5{f_x1}} & lane(mod5(8'(x) + 8'd1), y))      |
        ({5{f_x2}} & lane(mod5(8'(x) + 8'd2), y))      |
        ({5{f_x4}} & lane(mod5(8'(x) + 8'd4), y))      |
        ({5{f_yx}} & lane(y, mod5(8'(x) * 8'd2 + 8'(y) * 8'd3)));

    assign result_sha3 = {{(XL-5){1'b0}}, sha3_lane} << asi_shamt;

    // ------------------------------------------------------------
    // SHA-256 sigma
    always_comb begin
        case (sha2_ss)
            asi_isa_pkg::F_SHA2_S0_SMALL:
                result_sha2 = ror(sha2_rs1, 7)  ^ ror(sha2_rs1, 18) ^ (sha2_rs1 >> 3);
            asi_isa_pkg::F_SHA2_S1_SMALL:
                result_sha2 = ror(sha2_rs1, 17) ^ ror(sha2_rs1, 19) ^ (sha2_rs1 >> 10);
            asi_isa_pkg::F_SHA2_S0_BIG:
                result_sha2 = ror(sha2_rs1, 2)  ^ ror(sha2_rs1, 13) ^ ror(sha2_rs1, 22);
            default:  // Sigma1
                result_sha2 = ror(sha2_rs1, 6)  ^ ror(sha2_rs1, 11) ^ ror(sha2_rs1, 25);
        endcase
    end

endmodule

// ==== asi_top.f ====
asi_isa_pkg.sv
asi_aes_pkg.sv
asi_decode.sv
asi_sha_execute.sv
asi_aes_execute.sv
asi_top.sv
asi_top_sva.sv
tb_asi_top.sv

// ==== asi_top.sv ====
// Algorithm specific instruction unit, top level
// - Decode, SHA and AES execute instances
// - One-hot AND-OR result select
// - Merged ready level
`timescale 1ns/10ps

module asi_top #(
    parameter bit AES_SUB_FAST = 1'b1,  // Passed to the AES block
    parameter bit AES_MIX_FAST = 1'b1
) (
    input  logic                         g_clk,      // Global clock
    input  logic                         reset,      // Sync, active high
    input  logic                         asi_valid,  // Op present, held until ready
    input  asi_isa_pkg::asi_uop_t        asi_uop,    // Which op
    input  logic [asi_isa_pkg::XLEN-1:0] asi_rs1,
    input  logic [asi_isa_pkg::XLEN-1:0] asi_rs2,
    input  logic [1:0]                   asi_shamt,  // SHA3 post shift
    output logic                         asi_ready,  // Op completes this cycle
    output logic [asi_isa_pkg::XLEN-1:0] asi_result
);

    localparam int XL = asi_isa_pkg::XLEN;

    logic          cls_aes, cls_sha2, cls_sha3, cls_none;
    logic          f_xy, f_x1, f_x2, f_x4, f_yx;
    logic [XL-1:0] sha2_rs1;
    logic [1:0]    sha2_ss;
    logic          aes_mix, aes_dec, aes_ready;
    logic [XL-1:0] result_aes, result_sha2, result_sha3;

    // ------------------------------------------------------------
    asi_decode u_decode (
        .asi_valid (asi_valid), .asi_uop (asi_uop), .asi_rs1 (asi_rs1),
        .cls_aes   (cls_aes),   .cls_sha2 (cls_sha2), .cls_sha3 (cls_sha3),
        .cls_none  (cls_none),
        .f_xy (f_xy), .f_x1 (f_x1), .f_x2 (f_x2), .f_x4 (f_x4), .f_yx (f_yx),
        .sha2_rs1  (sha2_rs1),  .sha2_ss (sha2_ss),
        .aes_mix   (aes_mix),   .aes_dec (aes_dec)
    );

    asi_sha_execute u_sha (
        .asi_rs1 (asi_rs1), .asi_rs2 (asi_rs2), .asi_shamt (asi_shamt),
        .f_xy (f_xy), .f_x1 (f_x1), .f_x2 (f_x2), .f_x4 (f_x4), .f_yx (f_yx),
        .sha2_rs1    (sha2_rs1),    .sha2_ss (sha2_ss),
        .result_sha2 (result_sha2), .result_sha3 (result_sha3)
    );

    asi_aes_execute #(
        .AES_SUB_FAST (AES_SUB_FAST),
        .AES_MIX_FAST (AES_MIX_FAST)
    ) u_aes (
        .g_clk   (g_clk),   .reset   (reset),   .cls_aes (cls_aes),
        .aes_mix (aes_mix), .aes_dec (aes_dec),
        .asi_rs1 (asi_rs1), .asi_rs2 (asi_rs2),
        .aes_ready (aes_ready), .result_aes (result_aes)
    );

    // ------------------------------------------------------------
    // Unknown class and idle both select nothing, so zero
    assign asi_result = ({XL{cls_aes}}  & result_aes)  |
                        ({XL{cls_sha2}} & result_sha2) |
                        ({XL{cls_sha3}} & result_sha3);

    assign asi_ready = cls_sha2 || cls_sha3 || cls_none || (cls_aes && aes_ready);

endmodule

// ==== asi_top_sva.sv ====
// Bound assertions for the instruction unit top level
// - Zero result while valid is low
// - Ready only together with valid
// - Byte-serial AES ready exactly on the fourth held cycle
`timescale 1ns/10ps

module asi_top_sva #(
    parameter bit AES_SUB_FAST = 1'b1,
    parameter bit AES_MIX_FAST = 1'b1
) (
    input logic                         g_clk,
    input logic                         reset,
    input logic                         asi_valid,
    input asi_isa_pkg::asi_uop_t        asi_uop,
    input logic                         asi_ready,
    input logic [asi_isa_pkg::XLEN-1:0] asi_result
);

    logic       aes_iter;  // Valid AES op in byte-serial form
    logic [2:0] held;      // Cycles the current op has already waited

    assign aes_iter = asi_valid && (asi_uop.aes.cls == asi_isa_pkg::CLS_AES) &&
                      (asi_uop.aes.mix ? !AES_MIX_FAST : !AES_SUB_FAST);

    always_ff @(posedge g_clk) begin
        if (reset) begin
            held <= 3'd0;
        end else if (asi_valid && !asi_ready) begin
            held <= (held == 3'd7) ? held : held + 3'd1;  // Saturates
        end else begin
            held <= 3'd0;  // Completed or idle
        end
    end

    // ------------------------------------------------------------
    a_idle_zero: assert property (@(posedge g_clk) disable iff (reset)
        !asi_valid |-> (asi_result == '0))
        else $error("asi_result not zero while asi_valid is low");

    a_ready_valid: assert property (@(posedge g_clk) disable iff (reset)
        asi_ready |-> asi_valid)
        else $error("asi_ready high without asi_valid");

    a_iter_ready: assert property (@(posedge g_clk) disable iff (reset)
        aes_iter |-> (asi_ready == (held == 3'd3)))
        else $error("serial AES ready outside its fourth cycle");

endmodule

bind asi_top asi_top_sva #(
    .AES_SUB_FAST (AES_SUB_FAST),
    .AES_MIX_FAST (AES_MIX_FAST)
) u_sva (
    .g_clk      (g_clk),
    .reset      (reset),
    .asi_valid  (asi_valid),
    .asi_uop    (asi_uop),
    .asi_ready  (asi_ready),
    .asi_result (asi_result)
);

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_asi_top -f asi_top.f -o sim_asi \
    || { echo "Verilator build failed"; exit 1; }
out="$(./obj_dir/sim_asi 2>&1)"
echo "$out"
echo "$out" | grep -qx "Test completed successfully" && exit 0 || exit 1

// ==== tb_asi_top.sv ====
// Directed testbench for the algorithm specific instruction unit
// - Clock, reset and operand drive
// - Typed compare tasks for result word and ready level
// - SHA-256, SHA3, AES SubBytes, AES MixColumns, unknown and idle tests
`timescale 1ns/10ps

module tb_asi_top;

    localparam int XL = asi_isa_pkg::XLEN;
    localparam int READY_TIMEOUT = 16;  // Cycles, serial AES needs 4

    logic                  g_clk;
    logic                  reset;
    logic                  asi_valid;
    asi_isa_pkg::asi_uop_t asi_uop;
    logic [XL-1:0]         asi_rs1;
    logic [XL-1:0]         asi_rs2;
    logic [1:0]            asi_shamt;
    logic                  asi_ready;
    logic [XL-1:0]         asi_result;
    integer                seed;

    // Fast SubBytes, byte-serial MixColumns
    asi_top #(.AES_SUB_FAST (1'b1), .AES_MIX_FAST (1'b0)) DUT (
        .g_clk (g_clk), .reset (reset), .asi_valid (asi_valid), .asi_uop (asi_uop),
        .asi_rs1 (asi_rs1), .asi_rs2 (asi_rs2), .asi_shamt (asi_shamt),
        .asi_ready (asi_ready), .asi_result (asi_result)
    );

    initial begin
        g_clk = 1'b0;
        forever #4 g_clk = ~g_clk;  // 8 ns period
    end

    // ------------------------------------------------------------
    // Failure reporting and compares
    task automatic stop_on_failure();
        $display("Test failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic compare_word(input string name, input logic [XL-1:0] got,
                                input logic [XL-1:0] exp);
        if (got !== exp) begin
            $display("ERROR: %s is 0x%h, expected 0x%h", name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic compare_ready(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR: %s is 0x%h, expected 0x%h", name, got, exp);
            stop_on_failure();
        end
    endtask

    // ------------------------------------------------------------
    // Reference models
    function automatic logic [XL-1:0] rotr(input logic [XL-1:0] w, input int n);
        logic [2*XL-1:0] d;
        d = {w, w};
        return d[n +: XL];
    endfunction

    function automatic logic [XL-1:0] sigma_ref(input logic [XL-1:0] w, input int sel);
        case (sel)
            0:       return rotr(w, 7) ^ rotr(w, 18) ^ (w >> 3);
            1:       return rotr(w, 17) ^ rotr(w, 19) ^ (w >> 10);
            2:       return rotr(w, 2) ^ rotr(w, 13) ^ rotr(w, 22);
            default: return rotr(w, 6) ^ rotr(w, 11) ^ rotr(w, 25);
        endcase
    endfunction

    // Lane index from low bytes, then post shift
    function automatic logic [XL-1:0] sha3_ref(input int fn, input logic [XL-1:0] rs1,
                                               input logic [XL-1:0] rs2, input int shamt);
        int a;
        int b;
        int idx;
        a = int'(rs1[7:0]);
        b = int'(rs2[7:0]);
        case (fn)
            0:       idx = (a % 5) + 5 * (b % 5);
            1:       idx = ((a + 1) % 5) + 5 * (b % 5);
            2:       idx = ((a + 2) % 5) + 5 * (b % 5);
            3:       idx = ((a + 4) % 5) + 5 * (b % 5);
            4:       idx = (b % 5) + 5 * ((2 * a + 3 * b) % 5);
            default: idx = 0;  // Codes 5..7
        endcase
        return XL'(idx) << shamt;
    endfunction

    function automatic asi_isa_pkg::asi_uop_t make_func_uop(input logic [1:0] cls,
                                                            input logic [2:0] fn);
        asi_isa_pkg::asi_uop_t u;
        u.func.cls = cls;
        u.func.fn  = fn;
        return u;
    endfunction

    function automatic asi_isa_pkg::asi_uop_t make_aes_uop(input logic mix, input logic dec);
        asi_isa_pkg::asi_uop_t u;
        u.aes.cls  = asi_isa_pkg::CLS_AES;
        u.aes.rsvd = 1'b0;
        u.aes.mix  = mix;
        u.aes.dec  = dec;
        return u;
    endfunction

    // ------------------------------------------------------------
    // Drive one op, wait for ready, check latency and result
    task automatic wait_ready(output int cycles);
        cycles = 1;
        @(negedge g_clk);
        while (asi_ready !== 1'b1) begin
            if (cycles >= READY_TIMEOUT) begin
                $display("No asi_ready within %0d cycles of asi_valid", cycles);
                stop_on_failure();
            end else begin
                @(negedge g_clk);
                cycles++;
            end
        end
    endtask

    task automatic run_op(input string name, input asi_isa_pkg::asi_uop_t uop,
                          input logic [XL-1:0] rs1, input logic [XL-1:0] rs2,
                          input logic [1:0] shamt, input logic [XL-1:0] exp,
                          input int exp_cycles);
        int cycles;
        @(posedge g_clk);
        asi_valid <= 1'b1;
        asi_uop   <= uop;
        asi_rs1   <= rs1;
        asi_rs2   <= rs2;
        asi_shamt <= shamt;
        wait_ready(cycles);
        if (cycles != exp_cycles) begin
            $display("%s op was ready after %0d cycles, not %0d", name, cycles, exp_cycles);
            stop_on_failure();
        end
        compare_word("asi_result", asi_result, exp);
        @(posedge g_clk);
        asi_valid <= 1'b0;  // One idle cycle between ops
    endtask

    // ------------------------------------------------------------
    // Directed tests
    task automatic test_sha2();
        logic [XL-1:0] w;
        for (int s = 0; s < 4; s++) begin
            for (int n = 0; n < 20; n++) begin
                w = $random(seed);
                run_op("SHA-256", make_func_uop(asi_isa_pkg::CLS_SHA2, 3'(s)), w,
                       $random(seed), 2'd0, sigma_ref(w, s), 1);
            end
        end
    endtask

    task automatic test_sha3();
        logic [XL-1:0] r1;
        logic [XL-1:0] r2;
        for (int f = 0; f < 8; f++) begin  // 5..7 expect zero
            for (int sh = 0; sh < 4; sh++) begin
                for (int n = 0; n < 3; n++) begin
                    r1 = $random(seed);
                    r2 = $random(seed);
                    run_op("SHA3", make_func_uop(asi_isa_pkg::CLS_SHA3, 3'(f)), r1, r2,
                           2'(sh), sha3_ref(f, r1, r2, sh), 1);
                end
            end
        end
    endtask

    task automatic test_aes_sub();
        logic [XL-1:0] r1;
        logic [XL-1:0] enc;
        logic [XL-1:0] dec;
        // Standard S-box entries 00, 53, 01, ff
        run_op("SubBytes", make_aes_uop(1'b0, 1'b0), 32'hff015300, '0, 2'd0, 32'h167ced63, 1);
        for (int n = 0; n < 10; n++) begin
            r1 = $random(seed);
            for (int i = 0; i < 4; i++) begin
                enc[8*i +: 8] = asi_aes_pkg::aes_sbox(r1[8*i +: 8]);
                dec[8*i +: 8] = asi_aes_pkg::aes_inv_sbox(r1[8*i +: 8]);
            end
            run_op("SubBytes", make_aes_uop(1'b0, 1'b0), r1, $random(seed), 2'd0, enc, 1);
            run_op("InvSubBytes", make_aes_uop(1'b0, 1'b1), r1, $random(seed), 2'd0, dec, 1);
            run_op("InvSubBytes", make_aes_uop(1'b0, 1'b1), enc, $random(seed), 2'd0, r1, 1);
        end
    endtask

    task automatic test_aes_mix();
        logic [XL-1:0] r1;
        logic [XL-1:0] r2;
        logic [31:0]   col;
        // Standard column db 13 53 45 <-> 8e 4d a1 bc
        run_op("MixColumns", make_aes_uop(1'b1, 1'b0), 32'h000013db, 32'h45530000, 2'd0,
               32'hbca14d8e, 4);
        run_op("InvMixColumns", make_aes_uop(1'b1, 1'b1), 32'h00004d8e, 32'hbca10000, 2'd0,
               32'h455313db, 4);
        for (int n = 0; n < 10; n++) begin
            r1  = $random(seed);
            r2  = $random(seed);
            col = {r2[31:16], r1[15:0]};  // Bytes 0,1 of rs1 and 2,3 of rs2
            run_op("MixColumns", make_aes_uop(1'b1, 1'b0), r1, r2, 2'd0,
                   asi_aes_pkg::aes_mix_col(col), 4);
            run_op("InvMixColumns", make_aes_uop(1'b1, 1'b1), r1, r2, 2'd0,
                   asi_aes_pkg::aes_inv_mix_col(col), 4);
        end
    endtask

    task automatic test_unknown_and_idle();
        for (int i = 0; i < 8; i++) begin
            run_op("unknown class", make_func_uop(asi_isa_pkg::CLS_NONE, 3'(i)),
                   $random(seed), $random(seed), 2'(i), '0, 1);
        end
        for (int i = 0; i < 5; i++) begin
            @(posedge g_clk);
            asi_valid <= 1'b0;
            asi_uop   <= (i == 4) ? make_aes_uop(1'b1, 1'b0) : make_func_uop(2'(i), 3'(i));
            asi_rs1   <= $random(seed);
            asi_rs2   <= $random(seed);
            @(negedge g_clk);
            compare_ready("asi_ready", asi_ready, 1'b0);
            compare_word("asi_result", asi_result, '0);
        end
    endtask

    // ------------------------------------------------------------
    initial begin
        seed      = 32'hca8a;
        reset     = 1'b1;
        asi_valid = 1'b0;
        asi_uop   = '0;
        asi_rs1   = '0;
        asi_rs2   = '0;
        asi_shamt = 2'd0;
        repeat (4) @(posedge g_clk);
        reset <= 1'b0;
        @(negedge g_clk);
        compare_ready("asi_ready", asi_ready, 1'b0);  // Idle after reset
        test_sha2();
        test_sha3();
        test_aes_sub();
        test_aes_mix();
        test_unknown_and_idle();
        $display("Test completed successfully");
        $finish;
    end

endmodule
